// File: Bender.yml
package:
  name: masku_pred

sources:
  - include_dirs:
      - design
    files:
      - design/masku_pkg.sv
      - design/masku_predication_gen.sv
      - design/masku_pred_sequencer.sv
      - design/masku_pred_tail_reg.sv
      - design/masku_pred_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_masku_pred.sv

// File: design/masku_consts.svh
// Lane count must be a power of two; VLEN and ELEN sizes set every width in the mask unit
`ifndef MASKU_CONSTS_SVH
`define MASKU_CONSTS_SVH

// Number of lanes, power of two only
`define MASKU_NR_LANES 4

// Lane datapath width in bits
`define MASKU_ELEN 64

// Vector register length in bits
// The vl field is sized to count up to this many elements
`define MASKU_VLEN 1024

`endif

// File: design/masku_pkg.sv
// Types for the predication path; shuffle_index assumes a power-of-two lane count
`include "masku_consts.svh"

package masku_pkg;

  // Element width encoding, as in vtype.vsew
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // One lane's datapath word
  typedef logic [`MASKU_ELEN-1:0] elen_t;

  // Element count, up to VLEN elements of one byte with grouping
  typedef logic [$clog2(`MASKU_VLEN+1)-1:0] vlen_t;

  // Instruction fields seen by the predication path
  typedef struct packed {
    vlen_t vl;
    vew_e  vsew;
    // Width the mask register was last written with
    vew_e  eew_vmask;
    // Set for unmasked instructions
    logic  vm;
  } pe_req_t;

  // One beat handed from the sequencer to the output stage
  typedef struct packed {
    // Elements still pending before this beat
    vlen_t elems_left;
    vew_e  vsew;
    logic  vm;
    logic  last;
  } pred_beat_t;

  // Map a sequential byte index onto the lane-shuffled register layout
  // Element e goes to lane e % nr_lanes at slot e / nr_lanes
  function automatic int unsigned shuffle_index(int unsigned byte_index,
                                                int unsigned nr_lanes,
                                                vew_e        ew);
    int unsigned word_bytes;
    int unsigned word_base;
    int unsigned rest;
    int unsigned elem;
    int unsigned elem_byte;
    int unsigned lane;
    int unsigned slot;
    word_bytes = (`MASKU_ELEN / 8) * nr_lanes;
    // Whole register words keep their position
    rest       = byte_index % word_bytes;
    word_base  = byte_index - rest;
    elem       = rest >> ew;
    elem_byte  = rest & ((1 << ew) - 1);
    lane       = elem % nr_lanes;
    slot       = elem / nr_lanes;
    return word_base + lane * (`MASKU_ELEN / 8) + (slot << ew) + elem_byte;
  endfunction

endpackage

// File: design/masku_pred_sequencer.sv
// Expects vl > 0; one mask word serves 64*NrLanes elements and is refetched when used up
`timescale 1ns/1ps
`include "masku_consts.svh"

module masku_pred_sequencer #(
  parameter int unsigned NrLanes  = `MASKU_NR_LANES,
  parameter int unsigned PntWidth = $clog2(`MASKU_ELEN * NrLanes) + 1
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           vinsn_valid_i,
  input  masku_pkg::pe_req_t             vinsn_i,
  input  logic                           mask_valid_i,
  input  masku_pkg::elen_t [NrLanes-1:0] mask_operand_i,
  input  logic                           beat_req_i,
  output logic                           busy_o,
  output logic                           mask_req_o,
  output masku_pkg::pe_req_t             pred_vinsn_o,
  output logic [PntWidth-1:0]            pred_pnt_o,
  output masku_pkg::elen_t [NrLanes-1:0] pred_operand_o,
  output masku_pkg::pred_beat_t          beat_o,
  output logic                           beat_valid_o
);

  // Mask bits held in one operand word
  localparam int unsigned MaskBits     = `MASKU_ELEN * NrLanes;
  // Elements per beat at byte width, one strobe byte each
  localparam int unsigned ElemsPerBeat = (`MASKU_ELEN / 8) * NrLanes;

  // Held instruction and mask operand
  masku_pkg::pe_req_t             vinsn_q;
  masku_pkg::elen_t [NrLanes-1:0] operand_q;

  // Control state
  logic                  busy_q;
  logic                  mask_valid_q;
  logic [PntWidth-1:0]   pnt_q;
  masku_pkg::vlen_t      elems_left_q;

  // Beat arithmetic
  masku_pkg::vlen_t      beat_elems;
  logic [PntWidth-1:0]   pnt_sum;
  logic                  beat_last;
  logic                  vinsn_accept;
  logic                  mask_accept;

  // 32 >> vsew elements per beat with four lanes
  assign beat_elems = masku_pkg::vlen_t'(ElemsPerBeat >> vinsn_q.vsew);
  assign pnt_sum    = pnt_q + beat_elems[PntWidth-1:0];
  // Last beat when the rest fits in one beat
  assign beat_last  = elems_left_q <= beat_elems;

  assign vinsn_accept = vinsn_valid_i && !busy_q;
  assign mask_accept  = mask_valid_i && mask_req_o;

  assign busy_o     = busy_q;
  assign mask_req_o = busy_q && !mask_valid_q;

  // A beat leaves in the cycle it is requested
  assign beat_valid_o      = beat_req_i && busy_q && mask_valid_q;
  assign beat_o.elems_left = elems_left_q;
  assign beat_o.vsew       = vinsn_q.vsew;
  assign beat_o.vm         = vinsn_q.vm;
  assign beat_o.last       = beat_last;

  // Generator reads the held state directly
  assign pred_vinsn_o   = vinsn_q;
  assign pred_pnt_o     = pnt_q;
  assign pred_operand_o = operand_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q       <= 1'b0;
      mask_valid_q <= 1'b0;
      pnt_q        <= '0;
      elems_left_q <= '0;
    end else begin
      if (vinsn_accept) begin
        busy_q       <= 1'b1;
        mask_valid_q <= 1'b0;
        pnt_q        <= '0;
        elems_left_q <= vinsn_i.vl;
      end
      if (mask_accept) begin
        mask_valid_q <= 1'b1;
      end
      if (beat_valid_o) begin
        elems_left_q <= elems_left_q - beat_elems;
        // Mask word used up, wrap and ask for the next one
        if (pnt_sum >= PntWidth'(MaskBits)) begin
          pnt_q        <= '0;
          mask_valid_q <= 1'b0;
        end else begin
          pnt_q <= pnt_sum;
        end
        if (beat_last) begin
          busy_q       <= 1'b0;
          mask_valid_q <= 1'b0;
        end
      end
    end
  end

  // Instruction and mask payload
  always_ff @(posedge clk_i) begin
    if (vinsn_accept) begin
      vinsn_q <= vinsn_i;
    end
    if (mask_accept) begin
      operand_q <= mask_operand_i;
    end
  end

  // Consumer may only pull beats once a mask word is in place
  a_beat_needs_mask : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    beat_req_i |-> busy_q && mask_valid_q)
    else $error("Beat requested without mask data");

  // Instructions are not queued here
  a_no_vinsn_while_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vinsn_valid_i |-> !busy_q)
    else $error("Instruction arrived while busy");

endmodule

// File: design/masku_pred_tail_reg.sv
// One cycle latency; strobe bytes past vl are zeroed, vm forces ones before that
`timescale 1ns/1ps
`include "masku_consts.svh"

module masku_pred_tail_reg #(
  parameter int unsigned NrLanes   = `MASKU_NR_LANES,
  parameter int unsigned StrbWidth = `MASKU_ELEN / 8
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              beat_valid_i,
  input  masku_pkg::pred_beat_t             beat_i,
  input  logic [NrLanes-1:0][StrbWidth-1:0] strb_i,
  output logic                              pred_valid_o,
  output logic [NrLanes-1:0][StrbWidth-1:0] pred_strb_o,
  output logic                              pred_last_o
);

  // Strobe bytes in one beat
  localparam int unsigned BeatBytes = NrLanes * StrbWidth;

  logic [NrLanes-1:0][StrbWidth-1:0] strb_d;
  logic [NrLanes-1:0][StrbWidth-1:0] strb_q;
  logic                              valid_q;
  logic                              last_q;

  always_comb begin
    int unsigned vrf_byte;
    int unsigned vrf_lane;
    int unsigned vrf_offset;
    int unsigned elem;

    strb_d = '0;

    for (int unsigned seq_byte = 0; seq_byte < NrLanes * StrbWidth; seq_byte++) begin
      // Same byte to element mapping as the generator
      vrf_byte   = masku_pkg::shuffle_index(seq_byte, NrLanes, beat_i.vsew);
      vrf_lane   = vrf_byte >> $clog2(StrbWidth);
      vrf_offset = vrf_byte & (StrbWidth - 1);
      elem       = seq_byte >> beat_i.vsew;

      // Unmasked ops write every body element
      strb_d[vrf_lane][vrf_offset] = beat_i.vm ? 1'b1 : strb_i[vrf_lane][vrf_offset];

      // Tail elements never write
      if (elem >= beat_i.elems_left) begin
        strb_d[vrf_lane][vrf_offset] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= beat_valid_i;
      last_q  <= beat_valid_i && beat_i.last;
    end
  end

  // Strobe payload held until the next beat
  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      strb_q <= strb_d;
    end
  end

  assign pred_valid_o = valid_q;
  assign pred_last_o  = last_q;
  assign pred_strb_o  = strb_q;

  // Every beat still has at least one body element
  a_beat_in_body : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    beat_valid_i |-> beat_i.elems_left != '0)
    else $error("Beat issued past the end of the vector");

  // Only the last beat may carry tail bytes
  a_tail_only_in_last : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    beat_valid_i && !beat_i.last |->
      beat_i.elems_left > masku_pkg::vlen_t'(BeatBytes >> beat_i.vsew))
    else $error("Tail elements in a beat not marked last");

endmodule

// File: design/masku_pred_top.sv
// No handshake; the consumer paces beats and must honour busy_o and mask_req_o
`timescale 1ns/1ps
`include "masku_consts.svh"

module masku_pred_top #(
  parameter int unsigned NrLanes   = `MASKU_NR_LANES,
  parameter int unsigned StrbWidth = `MASKU_ELEN / 8,
  parameter int unsigned PntWidth  = $clog2(`MASKU_ELEN * NrLanes) + 1
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              vinsn_valid_i,
  input  masku_pkg::pe_req_t                vinsn_i,
  input  logic                              mask_valid_i,
  input  masku_pkg::elen_t [NrLanes-1:0]    mask_operand_i,
  input  logic                              beat_req_i,
  output logic                              busy_o,
  output logic                              mask_req_o,
  output logic                              pred_valid_o,
  output logic [NrLanes-1:0][StrbWidth-1:0] pred_strb_o,
  output logic                              pred_last_o
);

  // Held state toward the generator
  masku_pkg::pe_req_t                pred_vinsn;
  logic [PntWidth-1:0]               pred_pnt;
  masku_pkg::elen_t [NrLanes-1:0]    pred_operand;

  // Beat toward the output stage
  masku_pkg::pred_beat_t             beat;
  logic                              beat_valid;
  logic [NrLanes-1:0][StrbWidth-1:0] raw_strb;

  masku_pred_sequencer #(
    .NrLanes  (NrLanes),
    .PntWidth (PntWidth)
  ) i_sequencer (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .vinsn_valid_i  (vinsn_valid_i),
    .vinsn_i        (vinsn_i),
    .mask_valid_i   (mask_valid_i),
    .mask_operand_i (mask_operand_i),
    .beat_req_i     (beat_req_i),
    .busy_o         (busy_o),
    .mask_req_o     (mask_req_o),
    .pred_vinsn_o   (pred_vinsn),
    .pred_pnt_o     (pred_pnt),
    .pred_operand_o (pred_operand),
    .beat_o         (beat),
    .beat_valid_o   (beat_valid)
  );

  masku_predication_gen #(
    .NrLanes   (NrLanes),
    .StrbWidth (StrbWidth),
    .PntWidth  (PntWidth)
  ) i_pred_gen (
    .vinsn_issue_i     (pred_vinsn),
    .masku_pred_pnt_i  (pred_pnt),
    .masku_operand_m_i (pred_operand),
    .masku_pred_strb_o (raw_strb)
  );

  masku_pred_tail_reg #(
    .NrLanes   (NrLanes),
    .StrbWidth (StrbWidth)
  ) i_tail_reg (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .beat_valid_i (beat_valid),
    .beat_i       (beat),
    .strb_i       (raw_strb),
    .pred_valid_o (pred_valid_o),
    .pred_strb_o  (pred_strb_o),
    .pred_last_o  (pred_last_o)
  );

endmodule

// File: design/masku_predication_gen.sv
// Purely combinational; pointer plus one beat must stay inside the held mask word
`timescale 1ns/1ps
`include "masku_consts.svh"

module masku_predication_gen #(
  parameter int unsigned NrLanes   = `MASKU_NR_LANES,
  // Bytes per lane word
  parameter int unsigned StrbWidth = `MASKU_ELEN / 8,
  // Bit pointer into the full mask operand, one extra bit for the wrap value
  parameter int unsigned PntWidth  = $clog2(`MASKU_ELEN * NrLanes) + 1
) (
  // Instruction currently being predicated
  input  masku_pkg::pe_req_t                   vinsn_issue_i,
  // First mask bit used by this beat
  input  logic [PntWidth-1:0]                  masku_pred_pnt_i,
  // Mask operand, shuffled by eew_vmask
  input  masku_pkg::elen_t [NrLanes-1:0]       masku_operand_m_i,
  output logic [NrLanes-1:0][StrbWidth-1:0]    masku_pred_strb_o
);

  always_comb begin
    int unsigned vrf_byte;
    int unsigned vrf_lane;
    int unsigned vrf_offset;
    int unsigned elem;
    int unsigned mask_seq_bit;
    int unsigned mask_byte;
    int unsigned mask_bit;
    int unsigned mask_lane;
    int unsigned mask_offset;

    masku_pred_strb_o = '0;

    for (int unsigned seq_byte = 0; seq_byte < NrLanes * StrbWidth; seq_byte++) begin
      // Where the destination byte lives in the register file word
      vrf_byte   = masku_pkg::shuffle_index(seq_byte, NrLanes, vinsn_issue_i.vsew);
      vrf_lane   = vrf_byte >> $clog2(StrbWidth);
      vrf_offset = vrf_byte & (StrbWidth - 1);

      // Element of this beat that owns the byte
      // Wider elements reuse one mask bit for several bytes
      elem = seq_byte >> vinsn_issue_i.vsew;

      // Sequential mask bit, offset by what earlier beats consumed
      mask_seq_bit = masku_pred_pnt_i + elem;

      // Mask bytes are shuffled with the width used when the mask was written
      mask_byte = masku_pkg::shuffle_index(mask_seq_bit >> 3, NrLanes,
                                           vinsn_issue_i.eew_vmask);
      mask_bit  = (mask_byte << 3) + (mask_seq_bit & 7);

      // Split into lane and bit within the lane word
      mask_lane   = mask_bit >> $clog2(`MASKU_ELEN);
      mask_offset = mask_bit & (`MASKU_ELEN - 1);

      masku_pred_strb_o[vrf_lane][vrf_offset] = masku_operand_m_i[mask_lane][mask_offset];
    end
  end

endmodule

// File: flist.f
+incdir+design
design/masku_pkg.sv
design/masku_predication_gen.sv
design/masku_pred_sequencer.sv
design/masku_pred_tail_reg.sv
design/masku_pred_top.sv
testbench/tb_clk_gen.sv
testbench/tb_masku_pred.sv

// File: testbench/tb_clk_gen.sv
// Free-running clock from time zero; reset is released once, on a falling edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ClkPeriodNs = 8,
  parameter int unsigned RstCycles   = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Reset held low for RstCycles rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: testbench/tb_masku_pred.sv
// Assumes four lanes of 64 bits and vl up to VLEN; one instruction in flight at a time
`timescale 1ns/1ps
`include "masku_consts.svh"

module tb_masku_pred;

  localparam int unsigned Lanes     = `MASKU_NR_LANES;
  localparam int unsigned WordBits  = `MASKU_ELEN * Lanes;
  localparam int unsigned BeatBytes = (`MASKU_ELEN / 8) * Lanes;
  localparam int unsigned MaxWords  = `MASKU_VLEN / WordBits;
  localparam int unsigned NrEntries = 8;
  localparam int unsigned StepLimit = 2000;
  localparam int unsigned RstLimit  = 100;

  // One stimulus row with the expected mask fetch count in words
  typedef struct packed {
    masku_pkg::vew_e  vsew;
    masku_pkg::vew_e  eew_vmask;
    masku_pkg::vlen_t vl;
    logic             vm;
    logic [2:0]       words;
  } entry_t;

  // Mixed vsew and eew_vmask widths over partial and full words; vm set in two rows
  entry_t stim_table [NrEntries] = '{
    '{masku_pkg::EW8,  masku_pkg::EW8,  11'd100,  1'b0, 3'd1},
    '{masku_pkg::EW16, masku_pkg::EW8,  11'd77,   1'b0, 3'd1},
    '{masku_pkg::EW32, masku_pkg::EW64, 11'd300,  1'b0, 3'd2},
    '{masku_pkg::EW64, masku_pkg::EW16, 11'd1024, 1'b0, 3'd4},
    '{masku_pkg::EW8,  masku_pkg::EW32, 11'd513,  1'b0, 3'd3},
    '{masku_pkg::EW16, masku_pkg::EW16, 11'd256,  1'b1, 3'd1},
    '{masku_pkg::EW64, masku_pkg::EW8,  11'd5,    1'b1, 3'd1},
    '{masku_pkg::EW32, masku_pkg::EW32, 11'd600,  1'b0, 3'd3}
  };

  logic                           clk;
  logic                           arst_n;
  logic                           vinsn_valid;
  masku_pkg::pe_req_t             vinsn;
  logic                           mask_valid;
  masku_pkg::elen_t [Lanes-1:0]   mask_operand;
  logic                           beat_req;
  logic                           busy;
  logic                           mask_req;
  logic                           pred_valid;
  logic [Lanes-1:0][7:0]          pred_strb;
  logic                           pred_last;

  // Reference state
  logic [`MASKU_VLEN-1:0] seq_mask;
  logic [WordBits-1:0]    mask_words [MaxWords];
  integer                 seed;
  int unsigned            check_cnt;
  int unsigned            err_cnt;
  int unsigned            timeout_cnt;
  logic                   stop_run;

  tb_clk_gen clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  masku_pred_top masku_pred_top_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .vinsn_valid_i  (vinsn_valid),
    .vinsn_i        (vinsn),
    .mask_valid_i   (mask_valid),
    .mask_operand_i (mask_operand),
    .beat_req_i     (beat_req),
    .busy_o         (busy),
    .mask_req_o     (mask_req),
    .pred_valid_o   (pred_valid),
    .pred_strb_o    (pred_strb),
    .pred_last_o    (pred_last)
  );

  // Element e of width w lands in lane e % Lanes at slot e / Lanes
  function automatic int unsigned lane_position(int unsigned seq_byte, int unsigned ew);
    int unsigned w;
    int unsigned e;
    w = 1 << ew;
    e = seq_byte / w;
    return (e % Lanes) * 8 + (e / Lanes) * w + seq_byte % w;
  endfunction

  // Mask bytes move as elements of eew_vmask width
  function automatic logic [WordBits-1:0] shuffled_word(logic [`MASKU_VLEN-1:0] mask,
                                                        int unsigned idx, int unsigned ew);
    logic [WordBits-1:0] word;
    word = '0;
    for (int unsigned s = 0; s < WordBits; s++) begin
      word[lane_position(s / 8, ew) * 8 + s % 8] = mask[idx * WordBits + s];
    end
    return word;
  endfunction

  // Strobe of one beat with tail bytes zero and body bytes forced on by vm
  function automatic logic [BeatBytes-1:0] expected_strb(entry_t e, logic [`MASKU_VLEN-1:0] mask,
                                                         int unsigned beat);
    logic [BeatBytes-1:0] strb;
    int unsigned          w;
    int unsigned          epb;
    int unsigned          g;
    logic                 en;
    strb = '0;
    w    = 1 << e.vsew;
    epb  = BeatBytes / w;
    for (int unsigned j = 0; j < epb; j++) begin
      g  = beat * epb + j;
      en = (g < e.vl) && (e.vm || mask[g]);
      for (int unsigned b = 0; b < w; b++) begin
        strb[lane_position(j * w + b, e.vsew)] = en;
      end
    end
    return strb;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // One instruction stepped once per falling edge
  task automatic run_entry(input entry_t e);
    int unsigned epb;
    int unsigned nbeats;
    int unsigned beats_req;
    int unsigned words;
    int unsigned steps;
    logic        loaded;
    logic        pending;
    logic        got_last;
    epb       = BeatBytes >> e.vsew;
    nbeats    = (e.vl + epb - 1) / epb;
    beats_req = 0;
    words     = 0;
    steps     = 0;
    loaded    = 1'b0;
    pending   = 1'b0;
    got_last  = 1'b0;
    for (int i = 0; i < `MASKU_VLEN / 32; i++) begin
      seq_mask[i*32 +: 32] = $random(seed);
    end
    for (int unsigned w = 0; w < MaxWords; w++) begin
      mask_words[w] = shuffled_word(seq_mask, w, e.eew_vmask);
    end
    vinsn       = '{vl: e.vl, vsew: e.vsew, eew_vmask: e.eew_vmask, vm: e.vm};
    vinsn_valid = 1'b1;
    @(negedge clk);
    vinsn_valid = 1'b0;
    while (!got_last && !stop_run && steps < StepLimit) begin
      // Model state reflects the drives of the previous edge
      check_eq("busy_o", busy, beats_req < nbeats);
      check_eq("mask_req_o", mask_req, (beats_req < nbeats) && !loaded);
      check_eq("pred_valid_o", pred_valid, pending);
      check_eq("pred_last_o", pred_last, pending && (beats_req == nbeats));
      if (pending) begin
        check_eq("pred_strb_o", pred_strb, expected_strb(e, seq_mask, beats_req - 1));
        got_last = pred_last;
      end
      pending    = 1'b0;
      mask_valid = 1'b0;
      beat_req   = 1'b0;
      if (!got_last) begin
        if (mask_req && words < MaxWords) begin
          mask_operand = mask_words[words];
          mask_valid   = 1'b1;
          words++;
          loaded = 1'b1;
        end else if (mask_req) begin
          $display("More mask words were requested than the vector holds");
          err_cnt++;
          stop_run = 1'b1;
        end else if (beats_req < nbeats) begin
          beat_req = 1'b1;
          beats_req++;
          pending = 1'b1;
          // A full mask word has been consumed
          if ((beats_req * epb) % WordBits == 0) begin
            loaded = 1'b0;
          end
        end
        @(negedge clk);
      end
      steps++;
    end
    if (!got_last && !stop_run) begin
      $display("Timed out waiting for the last beat after %0d cycles", StepLimit);
      timeout_cnt++;
      stop_run = 1'b1;
    end else if (got_last) begin
      check_eq("beat count", beats_req, nbeats);
      check_eq("mask word count", words, e.words);
    end
  endtask

  initial begin
    int unsigned t;
    seed         = 32'h3019_b82f;
    check_cnt    = 0;
    err_cnt      = 0;
    timeout_cnt  = 0;
    stop_run     = 1'b0;
    vinsn_valid  = 1'b0;
    vinsn        = '0;
    mask_valid   = 1'b0;
    mask_operand = '0;
    beat_req     = 1'b0;
    t            = 0;
    while (arst_n !== 1'b1 && t < RstLimit) begin
      @(negedge clk);
      t++;
    end
    if (arst_n !== 1'b1) begin
      $display("Timed out waiting for reset release");
      timeout_cnt++;
      stop_run = 1'b1;
    end else begin
      @(negedge clk);
      check_eq("busy_o", busy, 1'b0);
      check_eq("mask_req_o", mask_req, 1'b0);
      check_eq("pred_valid_o", pred_valid, 1'b0);
      check_eq("pred_last_o", pred_last, 1'b0);
    end
    for (int i = 0; i < NrEntries && !stop_run; i++) begin
      run_entry(stim_table[i]);
    end
    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
